/* hbm_params.svh */
`ifndef HBM_PARAMS_SVH
`define HBM_PARAMS_SVH

// width of one data beat, kept to whole 32-bit lanes
`define HBM_PHIT_W 256

`define HBM_ADDR_W 33 // byte address, ignored inside

// burst length field, beats minus one
`define HBM_LEN_W 8

`define HBM_IDX_W 8 // beat counter inside a burst

`endif

/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // response codes on the write response channel
    typedef enum logic [1:0] {
        resp_okay   = 2'b00, // burst matched its length
        resp_slverr = 2'b10  // wlast early or missing
    } axi_resp_e;

endpackage

`default_nettype wire

/* emu_pkg.sv */
`default_nettype none

package emu_pkg;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } emu_op_e;

    typedef enum logic [1:0] {
        dec_idle     = 2'd0,
        dec_accept_r = 2'd1, // arready pulse cycle
        dec_accept_w = 2'd2, // awready pulse cycle
        dec_busy     = 2'd3  // waiting for cmd_done
    } dec_state_e;

    typedef enum logic [1:0] {
        seq_idle   = 2'd0,
        seq_read   = 2'd1,
        seq_write  = 2'd2,
        seq_finish = 2'd3 // write completion waiting for hand-off
    } seq_state_e;

endpackage

`default_nettype wire

/* emu_ifs.sv */
`default_nettype none

`include "hbm_params.svh"

// one burst command from decode to execute
interface burst_cmd_if import emu_pkg::*; ();

    logic                  cmd_valid; // single-cycle pulse
    emu_op_e               cmd_op;
    logic [`HBM_LEN_W-1:0] cmd_len;   // beats minus one
    logic                  cmd_done;  // burst finished, decoder may go on

    modport decode (
        output cmd_valid,
        output cmd_op,
        output cmd_len,
        input  cmd_done
    );

    modport exec (
        input  cmd_valid,
        input  cmd_op,
        input  cmd_len,
        output cmd_done
    );

endinterface

// beats from execute to result, valid/ready
interface beat_if import emu_pkg::*; ();

    logic                  beat_valid;
    emu_op_e               beat_op;
    logic [`HBM_IDX_W-1:0] beat_idx;
    logic                  beat_last;
    logic                  beat_err;   // write bursts only
    logic                  beat_ready;

    modport exec (
        output beat_valid,
        output beat_op,
        output beat_idx,
        output beat_last,
        output beat_err,
        input  beat_ready
    );

    modport result (
        input  beat_valid,
        input  beat_op,
        input  beat_idx,
        input  beat_last,
        input  beat_err,
        output beat_ready
    );

endinterface

`default_nettype wire

/* axi_addr_decode.sv */
`default_nettype none

`include "hbm_params.svh"

module axi_addr_decode import emu_pkg::*; (
    input  logic                  ap_clk,
    input  logic                  rst,
    input  logic                  arvalid,
    input  logic [`HBM_LEN_W-1:0] arlen,
    input  logic                  awvalid,
    input  logic [`HBM_LEN_W-1:0] awlen,
    output logic                  arready,
    output logic                  awready,
    burst_cmd_if.decode           cmd
);

    dec_state_e state;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            state         <= dec_idle;
            arready       <= 1'b0;
            awready       <= 1'b0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            arready       <= 1'b0; // both readies are one-cycle pulses
            awready       <= 1'b0;
            cmd.cmd_valid <= 1'b0;
            case (state)
                dec_idle: begin
                    if (arvalid) begin // read wins a tie
                        state   <= dec_accept_r;
                        arready <= 1'b1;
                    end else if (awvalid) begin
                        state   <= dec_accept_w;
                        awready <= 1'b1;
                    end
                end
                dec_accept_r, dec_accept_w: begin
                    state         <= dec_busy;
                    cmd.cmd_valid <= 1'b1; // command right after the handshake
                end
                dec_busy: begin
                    if (cmd.cmd_done) begin
                        state <= dec_idle;
                    end
                end
                default: state <= dec_idle;
            endcase
        end
    end

    // op and length captured when the request is first seen
    always_ff @(posedge ap_clk) begin
        if (state == dec_idle) begin
            if (arvalid) begin
                cmd.cmd_op  <= op_read;
                cmd.cmd_len <= arlen;
            end else if (awvalid) begin
                cmd.cmd_op  <= op_write;
                cmd.cmd_len <= awlen;
            end
        end
    end

endmodule

`default_nettype wire

/* burst_sequencer.sv */
`default_nettype none

`include "hbm_params.svh"

module burst_sequencer import emu_pkg::*; (
    input  logic      ap_clk,
    input  logic      rst,
    input  logic      wvalid,
    input  logic      wlast,
    output logic      wready,
    burst_cmd_if.exec cmd,
    beat_if.exec      beat
);

    seq_state_e            state;
    emu_op_e               op_q;
    logic [`HBM_LEN_W-1:0] len_q;
    logic [`HBM_IDX_W-1:0] idx_q; // read beat index or write beat count
    logic                  err_q;
    logic                  at_end;
    logic                  beat_take;
    logic                  w_fire;

    assign at_end    = (idx_q == len_q);
    assign beat_take = beat.beat_valid && beat.beat_ready;

    // result stage holds wready low while a response or read beat is pending
    assign wready = (state == seq_write) && beat.beat_ready;
    assign w_fire = wvalid && wready;

    assign beat.beat_valid = (state == seq_read) || (state == seq_finish);
    assign beat.beat_op    = op_q;
    assign beat.beat_idx   = idx_q;
    assign beat.beat_last  = (state == seq_finish) || at_end;
    assign beat.beat_err   = err_q;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            state        <= seq_idle;
            cmd.cmd_done <= 1'b0;
        end else begin
            cmd.cmd_done <= 1'b0;
            case (state)
                seq_idle: begin
                    if (cmd.cmd_valid) begin
                        state <= (cmd.cmd_op == op_read) ? seq_read : seq_write;
                    end
                end
                seq_read: begin
                    if (beat_take && at_end) begin
                        state        <= seq_idle;
                        cmd.cmd_done <= 1'b1;
                    end
                end
                seq_write: begin
                    if (w_fire && (wlast || at_end)) begin
                        state <= seq_finish; // early wlast also ends the burst
                    end
                end
                seq_finish: begin
                    if (beat_take) begin
                        state        <= seq_idle;
                        cmd.cmd_done <= 1'b1;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state == seq_idle && cmd.cmd_valid) begin
            op_q  <= cmd.cmd_op;
            len_q <= cmd.cmd_len;
            idx_q <= '0;
            err_q <= 1'b0;
        end else if (state == seq_read && beat_take && !at_end) begin
            idx_q <= idx_q + 1'b1;
        end else if (state == seq_write && w_fire) begin
            idx_q <= idx_q + 1'b1;
            err_q <= (wlast != at_end); // wlast must fall exactly on beat len+1
        end
    end

endmodule

`default_nettype wire

/* float_pattern_gen.sv */
`default_nettype none

`include "hbm_params.svh"

module float_pattern_gen (
    input  logic [`HBM_IDX_W-1:0] idx,
    output logic [31:0]           value
);

    localparam int POS_W = $clog2(`HBM_IDX_W);

    logic [POS_W-1:0] lead;    // position of the leading one
    logic [7:0]       exp_b;   // biased exponent
    logic [31:0]      shifted; // hidden bit lands on bit 23

    always_comb begin
        lead = '0;
        for (int i = 0; i < `HBM_IDX_W; i++) begin
            if (idx[i]) begin
                lead = POS_W'(i);
            end
        end
    end

    // exact, every index fits in the 24-bit significand
    assign exp_b   = 8'd127 + 8'(lead);
    assign shifted = 32'(idx) << (5'd23 - 5'(lead));

    always_comb begin
        if (idx == '0) begin
            value = 32'h0000_0000; // +0.0
        end else begin
            value = {1'b0, exp_b, shifted[22:0]};
        end
    end

endmodule

`default_nettype wire

/* beat_result.sv */
`default_nettype none

`include "hbm_params.svh"

module beat_result import axi_pkg::*, emu_pkg::*; (
    input  logic                   ap_clk,
    input  logic                   rst,
    input  logic                   rready,
    input  logic                   bready,
    output logic [`HBM_PHIT_W-1:0] rdata,
    output logic                   rvalid,
    output logic                   rlast,
    output logic                   bvalid,
    output axi_resp_e              bresp,
    beat_if.result                 beat
);

    localparam int LANES = `HBM_PHIT_W / 32;

    logic [31:0] lane_val;
    logic        rd_free;  // read register empty or draining this cycle
    logic        rd_take;
    logic        wr_take;

    float_pattern_gen float_pattern_gen_inst (
        .idx   (beat.beat_idx),
        .value (lane_val)
    );

    assign rd_free = !rvalid || rready;

    // a write response waits for any read beat still in the channel
    assign beat.beat_ready = (beat.beat_op == op_read) ? rd_free : (!bvalid && !rvalid);

    assign rd_take = beat.beat_valid && beat.beat_ready && (beat.beat_op == op_read);
    assign wr_take = beat.beat_valid && beat.beat_ready && (beat.beat_op == op_write);

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rd_take) begin
                rvalid <= 1'b1;
                rlast  <= beat.beat_last;
            end else if (rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end
            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0; // held until the master takes it
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rd_take) begin
            rdata <= {LANES{lane_val}}; // same float in every lane
        end
        if (wr_take) begin
            bresp <= beat.beat_err ? resp_slverr : resp_okay;
        end
    end

endmodule

`default_nettype wire

/* hbm_emulator.sv */
`default_nettype none

`include "hbm_params.svh"

module hbm_emulator import axi_pkg::*; (
    input  logic                     ap_clk,
    input  logic                     rst,

    input  logic [`HBM_ADDR_W-1:0]   araddr, // ignored
    input  logic [`HBM_LEN_W-1:0]    arlen,
    input  logic                     arvalid,
    output logic                     arready,

    input  logic [`HBM_ADDR_W-1:0]   awaddr, // ignored
    input  logic [`HBM_LEN_W-1:0]    awlen,
    input  logic                     awvalid,
    output logic                     awready,

    input  logic [`HBM_PHIT_W-1:0]   wdata,  // thrown away
    input  logic [`HBM_PHIT_W/8-1:0] wstrb,  // ignored
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,

    output logic [`HBM_PHIT_W-1:0]   rdata,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,

    output logic                     bvalid,
    output axi_resp_e                bresp,
    input  logic                     bready
);

    burst_cmd_if cmd_bus ();
    beat_if      beat_bus ();

    axi_addr_decode axi_addr_decode_inst (
        .ap_clk  (ap_clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arlen   (arlen),
        .awvalid (awvalid),
        .awlen   (awlen),
        .arready (arready),
        .awready (awready),
        .cmd     (cmd_bus.decode)
    );

    burst_sequencer burst_sequencer_inst (
        .ap_clk (ap_clk),
        .rst    (rst),
        .wvalid (wvalid),
        .wlast  (wlast),
        .wready (wready),
        .cmd    (cmd_bus.exec),
        .beat   (beat_bus.exec)
    );

    beat_result beat_result_inst (
        .ap_clk (ap_clk),
        .rst    (rst),
        .rready (rready),
        .bready (bready),
        .rdata  (rdata),
        .rvalid (rvalid),
        .rlast  (rlast),
        .bvalid (bvalid),
        .bresp  (bresp),
        .beat   (beat_bus.result)
    );

endmodule

`default_nettype wire

/* hbm_emulator_assertions.sv */
`default_nettype none

`include "hbm_params.svh"

module hbm_emulator_assertions (
    input logic                   ap_clk,
    input logic                   rst,
    input logic [`HBM_PHIT_W-1:0] rdata,
    input logic                   rvalid,
    input logic                   rready,
    input logic                   bvalid,
    input logic                   bready,
    input logic                   wready
);

    // read beat frozen under back-pressure
    assert property (@(posedge ap_clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read beat changed while rready was low");

    assert property (@(posedge ap_clk) disable iff (rst)
        bvalid && !bready |=> bvalid) // response held until taken
        else $error("bvalid dropped before bready");

    assert property (@(posedge ap_clk) disable iff (rst)
        !(wready && rvalid))
        else $error("wready and rvalid high together");

endmodule

bind hbm_emulator hbm_emulator_assertions hbm_emulator_assertions_inst (.*);

`default_nettype wire

/* tb_hbm_emulator.sv */
`default_nettype none

`include "hbm_params.svh"

module tb_hbm_emulator import axi_pkg::*; ();

    localparam int TMO = 400; // cycles allowed per wait

    logic                     ap_clk = 1'b0;
    logic                     rst;
    logic [`HBM_ADDR_W-1:0]   araddr;
    logic [`HBM_ADDR_W-1:0]   awaddr;
    logic [`HBM_LEN_W-1:0]    arlen;
    logic [`HBM_LEN_W-1:0]    awlen;
    logic [`HBM_PHIT_W-1:0]   wdata;
    logic [`HBM_PHIT_W/8-1:0] wstrb;
    logic                     arvalid;
    logic                     awvalid;
    logic                     wlast;
    logic                     wvalid;
    logic                     rready;
    logic                     bready;
    logic                     arready;
    logic                     awready;
    logic                     wready;
    logic [`HBM_PHIT_W-1:0]   rdata;
    logic                     rlast;
    logic                     rvalid;
    logic                     bvalid;
    axi_resp_e                bresp;

    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    logic [15:0] lfsr_q = 16'd28100;

    hbm_emulator hbm_emulator_inst (.*);

    always #5 ap_clk = ~ap_clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        return lfsr_q[0];
    endfunction

    // single float rebuilt from the double with the exponent rebiased from 1023 to 127
    function automatic logic [31:0] float_of(input int k);
        logic [63:0] d;
        d = $realtobits($itor(k));
        if (k == 0) begin
            return 32'h0000_0000;
        end
        return {d[63], 8'(d[62:52] - 11'd896), d[51:29]};
    endfunction

    task automatic check_data(input string name, input logic [`HBM_PHIT_W-1:0] got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_e got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        err_count++;
        $display("timeout while waiting for %s at time %0t", what, $time);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        $display("%-24s %s", name, (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic read_burst(input int len, input logic backpressure);
        int t;
        int count;
        arlen   = 8'(len);
        araddr  = 33'h1_0000_0000;
        arvalid = 1'b1;
        t = 0;
        while (!arready && t < TMO) begin
            @(negedge ap_clk);
            t++;
        end
        if (!arready) begin
            timed_out("arready");
        end
        check_bit("awready", awready, 1'b0); // read wins a tie
        @(negedge ap_clk);
        arvalid = 1'b0;
        count = 0;
        t = 0;
        while (count <= len && t < TMO) begin
            rready = backpressure ? rand_bit() : 1'b1;
            check_bit("awready", awready, 1'b0); // no write while the read runs
            if (rvalid && rready) begin // transfers on the next rising edge
                check_data("rdata", rdata, {(`HBM_PHIT_W / 32){float_of(count)}});
                check_bit("rlast", rlast, count == len);
                count++;
            end
            @(negedge ap_clk);
            t++;
        end
        if (count <= len) begin
            timed_out("read beats");
        end
        rready = 1'b0;
        check_bit("rvalid", rvalid, 1'b0); // no extra beat
        check_bit("awready", awready, 1'b0); // not yet, the last beat just left
    endtask

    task automatic write_burst(input int len, input int beats, input int last_at,
                               input axi_resp_e exp, input int b_delay);
        int t;
        int i;
        awlen   = 8'(len);
        awaddr  = 33'h0_0000_1000;
        awvalid = 1'b1;
        t = 0;
        while (!awready && t < TMO) begin
            @(negedge ap_clk);
            t++;
        end
        if (!awready) begin
            timed_out("awready");
        end
        @(negedge ap_clk);
        awvalid = 1'b0;
        for (i = 0; i < beats; i++) begin
            wdata  = {(`HBM_PHIT_W / 32){32'(i) ^ 32'hA5A5_0000}};
            wlast  = (i == last_at);
            wvalid = 1'b1;
            t = 0;
            while (!wready && t < TMO) begin
                @(negedge ap_clk);
                t++;
            end
            if (!wready) begin
                timed_out("wready");
            end
            @(negedge ap_clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        t = 0;
        while (!bvalid && t < TMO) begin
            @(negedge ap_clk);
            t++;
        end
        if (!bvalid) begin
            timed_out("bvalid");
        end
        check_resp("bresp", bresp, exp);
        check_bit("wready", wready, 1'b0); // held low while response pending
        repeat (b_delay) begin
            @(negedge ap_clk);
            check_bit("bvalid", bvalid, 1'b1);
        end
        bready = 1'b1;
        @(negedge ap_clk);
        bready = 1'b0;
        check_bit("bvalid", bvalid, 1'b0);
    endtask

    task automatic test_reset_state();
        int errs;
        errs = err_count;
        check_bit("arready", arready, 1'b0);
        check_bit("awready", awready, 1'b0);
        check_bit("wready", wready, 1'b0);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("rlast", rlast, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);
        end_test("reset_state", errs);
    endtask

    task automatic test_short_read();
        int errs;
        errs = err_count;
        read_burst(3, 1'b0);
        end_test("short_read", errs);
    endtask

    task automatic test_long_read_backpressure();
        int errs;
        errs = err_count;
        read_burst(15, 1'b1);
        end_test("long_read_backpressure", errs);
    endtask

    task automatic test_write_okay();
        int errs;
        errs = err_count;
        write_burst(5, 6, 5, resp_okay, 4);
        end_test("write_okay", errs);
    endtask

    task automatic test_write_errors();
        int errs;
        errs = err_count;
        write_burst(5, 3, 2, resp_slverr, 0); // wlast too early
        write_burst(2, 3, -1, resp_slverr, 1); // wlast never comes
        end_test("write_errors", errs);
    endtask

    task automatic test_read_before_write();
        int errs;
        errs = err_count;
        awlen   = 8'd5;
        awvalid = 1'b1; // raised together with arvalid
        read_burst(7, 1'b0);
        write_burst(5, 6, 5, resp_okay, 1);
        end_test("read_before_write", errs);
    endtask

    initial begin
        rst     = 1'b1;
        araddr  = '0;
        awaddr  = '0;
        arlen   = '0;
        awlen   = '0;
        wdata   = '0;
        wstrb   = '1;
        arvalid = 1'b0;
        awvalid = 1'b0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        rready  = 1'b0;
        bready  = 1'b0;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        rst = 1'b0;
        @(negedge ap_clk);
        test_reset_state();
        test_short_read();
        test_long_read_backpressure();
        test_write_okay();
        test_write_errors();
        test_read_before_write();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
axi_pkg.sv
emu_pkg.sv
emu_ifs.sv
axi_addr_decode.sv
burst_sequencer.sv
float_pattern_gen.sv
beat_result.sv
hbm_emulator.sv
hbm_emulator_assertions.sv
tb_hbm_emulator.sv

/* Makefile */
TOP = tb_hbm_emulator

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
